//--- verilog.f
+incdir+verification
hdl/mipsPkg.sv
hdl/cpuControl.sv
hdl/instrDecode.sv
hdl/aluExecute.sv
hdl/regWriteBack.sv
hdl/mipsCpuBus.sv
verification/cpuTb.sv

//--- run.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module cpuTb -f verilog.f
./obj_dir/VcpuTb | tee sim.log

# Result comes from the log
if grep -qxF '*** PASSED ***' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

//--- verification/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Program image, word i sits at resetVector + 4*i
word_t prog [$];
// Reference register file and memory, architectural byte order
word_t modelRegs [32];
word_t modelMem [word_t];
// Expected bus activity in program order
word_t expFetch [$];
word_t expStoreAddr [$];
word_t expStoreData [$];

function automatic word_t randWord();
    return $random(seed);
endfunction

function automatic int randBelow(input int n);
    word_t r;
    r = randWord();
    return int'(r % word_t'(n));
endfunction

function automatic regIdx_t randReg();
    return regIdx_t'(randBelow(32));
endfunction

// Untouched memory reads as a hash of the full address
function automatic word_t fillWord(input word_t addr);
    return (addr * 32'h9e3779b1) ^ 32'ha5a5c3c3;
endfunction

// Most significant byte travels in bus bits 7..0
function automatic word_t busOrder(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

function automatic word_t encR(input funct_t fn, input regIdx_t s, input regIdx_t t,
                               input regIdx_t d, input logic [4:0] sh);
    return {opSpecial, s, t, d, sh, fn};
endfunction

function automatic word_t encI(input opcode_t op, input regIdx_t s, input regIdx_t t,
                               input logic [15:0] imm);
    return {op, s, t, imm};
endfunction

// One random ALU or immediate instruction
task automatic addAlu();
    regIdx_t s;
    regIdx_t t;
    regIdx_t d;
    word_t r;
    s = randReg();
    t = randReg();
    d = randReg();
    r = randWord();
    case (randBelow(20))
        0: prog.push_back(encR(fnAddu, s, t, d, 5'd0));
        1: prog.push_back(encR(fnSubu, s, t, d, 5'd0));
        2: prog.push_back(encR(fnAnd, s, t, d, 5'd0));
        3: prog.push_back(encR(fnOr, s, t, d, 5'd0));
        4: prog.push_back(encR(fnXor, s, t, d, 5'd0));
        5: prog.push_back(encR(fnSlt, s, t, d, 5'd0));
        6: prog.push_back(encR(fnSltu, s, t, d, 5'd0));
        // Fixed shifts
        7: prog.push_back(encR(fnSll, 5'd0, t, d, r[20:16]));
        8: prog.push_back(encR(fnSrl, 5'd0, t, d, r[20:16]));
        9: prog.push_back(encR(fnSra, 5'd0, t, d, r[20:16]));
        // Variable shifts
        10: prog.push_back(encR(fnSllv, s, t, d, 5'd0));
        11: prog.push_back(encR(fnSrlv, s, t, d, 5'd0));
        12: prog.push_back(encR(fnSrav, s, t, d, 5'd0));
        13: prog.push_back(encI(opAddiu, s, t, r[15:0]));
        14: prog.push_back(encI(opAndi, s, t, r[15:0]));
        15: prog.push_back(encI(opOri, s, t, r[15:0]));
        16: prog.push_back(encI(opXori, s, t, r[15:0]));
        17: prog.push_back(encI(opLui, 5'd0, t, r[15:0]));
        18: prog.push_back(encI(opSlti, s, t, r[15:0]));
        default: prog.push_back(encI(opSltiu, s, t, r[15:0]));
    endcase
endtask

// LW or SW off r0 into the upper half of the data region
task automatic addMem();
    word_t a;
    a = dataBase + word_t'(4 * (32 + randBelow(32)));
    if (randBelow(2) == 0) begin
        prog.push_back(encI(opLw, 5'd0, randReg(), a[15:0]));
    end else begin
        prog.push_back(encI(opSw, 5'd0, randReg(), a[15:0]));
    end
endtask

// Forward branch or jump plus its delay slot
task automatic addRedirect(input int room);
    int off;
    word_t ta;
    regIdx_t s;
    regIdx_t u;
    off = 1 + randBelow((room - 1 < 4) ? room - 1 : 4);
    ta = resetVector + word_t'(4 * (prog.size() + 1 + off));
    s = randReg();
    // Same register now and then, so BEQ gets taken
    u = (randBelow(3) == 0) ? s : randReg();
    case (randBelow(3))
        0: prog.push_back(encI(opBeq, s, u, 16'(off)));
        1: prog.push_back(encI(opBne, s, u, 16'(off)));
        default: prog.push_back({opJ, ta[27:2]});
    endcase
    // Slot is always a plain ALU op
    addAlu();
endtask

task automatic genProgram();
    word_t r;
    word_t a;
    int i;
    // Seed r1..r31 with full random words
    for (i = 1; i < 32; i++) begin
        r = randWord();
        prog.push_back(encI(opLui, 5'd0, regIdx_t'(i), r[31:16]));
        prog.push_back(encI(opOri, regIdx_t'(i), regIdx_t'(i), r[15:0]));
    end
    while (prog.size() < seedLen + bodyLen) begin
        case (randBelow(8))
            0: begin
                if (seedLen + bodyLen - prog.size() >= 2) begin
                    addRedirect(seedLen + bodyLen - prog.size());
                end else begin
                    addAlu();
                end
            end
            1: addMem();
            default: addAlu();
        endcase
    end
    // Dump every register, then exit to address zero
    for (i = 0; i < 32; i++) begin
        a = dataBase + word_t'(4 * i);
        prog.push_back(encI(opSw, 5'd0, regIdx_t'(i), a[15:0]));
    end
    prog.push_back(encR(fnJr, 5'd0, 5'd0, 5'd0, 5'd0));
    prog.push_back(32'h0000_0000);
endtask

// Instruction level execution with one delay slot
task automatic runModel();
    word_t pc;
    word_t nextPc;
    word_t target;
    word_t ins;
    word_t rsV;
    word_t rtV;
    word_t immS;
    word_t res;
    word_t a;
    regIdx_t dest;
    logic pending;
    logic wr;
    logic done;
    int idx;
    int steps;
    for (idx = 0; idx < 32; idx++) begin
        modelRegs[idx] = '0;
    end
    pc = resetVector;
    target = '0;
    pending = 1'b0;
    done = 1'b0;
    steps = 0;
    while (!done) begin
        expFetch.push_back(pc);
        idx = int'((pc - resetVector) >> 2);
        if (pc == '0) begin
            done = 1'b1;
        end else if (pc < resetVector || idx >= prog.size() || steps > progLen) begin
            errors++;
            $display("Reference model left the program at %h", pc);
            done = 1'b1;
        end else begin
            ins = prog[idx];
            // A pending target replaces the increment after the slot
            nextPc = pending ? target : pc + 32'd4;
            pending = 1'b0;
            rsV = modelRegs[ins[25:21]];
            rtV = modelRegs[ins[20:16]];
            immS = {{16{ins[15]}}, ins[15:0]};
            res = '0;
            wr = 1'b1;
            dest = ins[20:16];
            case (ins[31:26])
                opSpecial: begin
                    dest = ins[15:11];
                    case (ins[5:0])
                        fnAddu: res = rsV + rtV;
                        fnSubu: res = rsV - rtV;
                        fnAnd:  res = rsV & rtV;
                        fnOr:   res = rsV | rtV;
                        fnXor:  res = rsV ^ rtV;
                        fnSlt:  res = ($signed(rsV) < $signed(rtV)) ? 32'd1 : 32'd0;
                        fnSltu: res = (rsV < rtV) ? 32'd1 : 32'd0;
                        fnSll:  res = rtV << ins[10:6];
                        fnSrl:  res = rtV >> ins[10:6];
                        fnSra:  res = word_t'($signed(rtV) >>> ins[10:6]);
                        fnSllv: res = rtV << rsV[4:0];
                        fnSrlv: res = rtV >> rsV[4:0];
                        fnSrav: res = word_t'($signed(rtV) >>> rsV[4:0]);
                        fnJr: begin
                            wr = 1'b0;
                            pending = 1'b1;
                            target = rsV;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                opAddiu: res = rsV + immS;
                opSlti:  res = ($signed(rsV) < $signed(immS)) ? 32'd1 : 32'd0;
                opSltiu: res = (rsV < immS) ? 32'd1 : 32'd0;
                opAndi:  res = rsV & {16'h0000, ins[15:0]};
                opOri:   res = rsV | {16'h0000, ins[15:0]};
                opXori:  res = rsV ^ {16'h0000, ins[15:0]};
                opLui:   res = {ins[15:0], 16'h0000};
                opLw: begin
                    a = rsV + immS;
                    res = modelMem.exists(a) ? modelMem[a] : fillWord(a);
                end
                opSw: begin
                    a = rsV + immS;
                    wr = 1'b0;
                    modelMem[a] = rtV;
                    expStoreAddr.push_back(a);
                    expStoreData.push_back(busOrder(rtV));
                end
                opBeq, opBne: begin
                    wr = 1'b0;
                    if ((rsV == rtV) == (ins[31:26] == opBeq)) begin
                        pending = 1'b1;
                        target = pc + 32'd4 + {immS[29:0], 2'b00};
                    end
                end
                opJ: begin
                    wr = 1'b0;
                    pending = 1'b1;
                    a = pc + 32'd4;
                    target = {a[31:28], ins[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            // r0 stays zero
            if (wr && dest != '0) begin
                modelRegs[dest] = res;
            end
            pc = nextPc;
            steps++;
        end
    end
endtask

`endif

//--- verification/cpuTb.sv
module cpuTb;
    timeunit 1ns;
    timeprecision 100ps;
    import mipsPkg::*;

    localparam word_t resetVector = defaultResetVector;
    // Seeding, random body, register dump plus JR and its slot
    localparam int seedLen = 62;
    localparam int bodyLen = 120;
    localparam int progLen = seedLen + bodyLen + 34;
    localparam word_t dataBase = 32'h1000;
    // Dump in words 0..31, random loads and stores in 32..63
    localparam word_t dataBytes = 32'd256;
    localparam int maxWait = 3;
    localparam int quietLen = 20;

    logic clk;
    logic reset;
    logic waitrequest;
    word_t readdata;
    logic active;
    word_t registerV0;
    word_t address;
    logic read;
    logic write;
    word_t writedata;
    logic [3:0] byteenable;

    integer seed;
    int errors;
    int cycles;
    int timeLimit;
    int fetches;
    int loads;
    int stores;
    int waitLeft;
    int quietCycles;
    logic inTransfer;
    logic firstAccess;
    logic halted;
    logic timedOut;
    word_t heldAddr;
    word_t lastFetch;
    // Bus memory, bus byte order
    word_t busMem [word_t];

    `include "isaModel.svh"

    mipsCpuBus #(.resetVector(resetVector)) u_dut (
        .clk(clk),
        .reset(reset),
        .active(active),
        .registerV0(registerV0),
        .address(address),
        .read(read),
        .write(write),
        .waitrequest(waitrequest),
        .writedata(writedata),
        .byteenable(byteenable),
        .readdata(readdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic checkWord(input string what, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic checkState(input string what, input logic actual, input logic expected);
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t: %s, got %b, expected %b", $time, what, actual, expected);
        end
    endtask

    function automatic word_t busRead(input word_t addr);
        return busMem.exists(addr) ? busMem[addr] : busOrder(fillWord(addr));
    endfunction

    // Transfer completes at the end of this cycle
    task automatic completeAccess();
        if (firstAccess) begin
            firstAccess = 1'b0;
            checkState("first access is a read", read, 1'b1);
            checkWord("first access address", address, resetVector);
        end
        if (write) begin
            checkState("byteenable all ones", &byteenable, 1'b1);
            if (expStoreAddr.size() == 0) begin
                errors++;
                $display("Unexpected write to %h at %0t", address, $time);
            end else begin
                checkWord("store address", address, expStoreAddr.pop_front());
                checkWord("store data", writedata, expStoreData.pop_front());
            end
            busMem[address] = writedata;
            stores++;
        end else if (address >= dataBase && address < dataBase + dataBytes) begin
            readdata = busRead(address);
            loads++;
        end else begin
            // Anything outside the data region is a fetch
            if (expFetch.size() == 0) begin
                errors++;
                $display("Fetch from %h after the program ended at %0t", address, $time);
            end else begin
                checkWord("fetch address", address, expFetch.pop_front());
            end
            lastFetch = address;
            readdata = busRead(address);
            fetches++;
        end
    endtask

    // Slave side, called once per cycle just after the rising edge
    task automatic serviceBus();
        if (read && write) begin
            errors++;
            $display("Read and write both high at %0t", $time);
        end
        if (!active && !halted) begin
            halted = 1'b1;
            checkWord("last fetch before halt", lastFetch, '0);
        end
        waitrequest = 1'b1;
        readdata = '1;
        if (halted) begin
            checkState("read after halt", read, 1'b0);
            checkState("write after halt", write, 1'b0);
            checkState("active after halt", active, 1'b0);
        end else if (read || write) begin
            if (!inTransfer) begin
                inTransfer = 1'b1;
                heldAddr = address;
                waitLeft = randBelow(maxWait + 1);
            end
            checkWord("address held during wait", address, heldAddr);
            if (waitLeft > 0) begin
                waitLeft--;
            end else begin
                waitrequest = 1'b0;
                inTransfer = 1'b0;
                completeAccess();
            end
        end
    endtask

    task automatic finalChecks();
        word_t a;
        int i;
        checkWord("registerV0 at halt", registerV0, modelRegs[regV0]);
        checkWord("dumped r0", busRead(dataBase), '0);
        for (i = 0; i < 64; i++) begin
            a = dataBase + word_t'(4 * i);
            if (i < 32) begin
                checkWord($sformatf("dumped r%0d", i), busRead(a), busOrder(modelRegs[i]));
            end else begin
                checkWord($sformatf("data word %h", a), busRead(a),
                          busOrder(modelMem.exists(a) ? modelMem[a] : fillWord(a)));
            end
        end
        if (expFetch.size() != 0 || expStoreAddr.size() != 0) begin
            errors++;
            $display("Core halted with %0d fetches and %0d stores still expected",
                     expFetch.size(), expStoreAddr.size());
        end
    endtask

    initial begin
        reset = 1'b1;
        waitrequest = 1'b1;
        readdata = '1;
        seed = 32'hcdfe246f;
        errors = 0;
        cycles = 0;
        fetches = 0;
        loads = 0;
        stores = 0;
        waitLeft = 0;
        quietCycles = 0;
        inTransfer = 1'b0;
        firstAccess = 1'b1;
        halted = 1'b0;
        timedOut = 1'b0;
        heldAddr = '0;
        lastFetch = resetVector;
        genProgram();
        runModel();
        for (int i = 0; i < prog.size(); i++) begin
            busMem[resetVector + word_t'(4 * i)] = busOrder(prog[i]);
        end
        // Worst case per instruction is LW with full waits on IF and MEM
        timeLimit = progLen * (5 + 2 * maxWait) + 100;

        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        checkState("active after reset", active, 1'b1);
        checkState("write after reset", write, 1'b0);
        checkState("read after reset", read, 1'b1);
        serviceBus();
        // Keep watching the bus for a while after halt
        while (quietCycles < quietLen && !timedOut) begin
            @(posedge clk);
            #2;
            cycles++;
            serviceBus();
            if (halted) begin
                quietCycles++;
            end
            if (cycles >= timeLimit) begin
                timedOut = 1'b1;
                $display("Timeout: the core did not halt within %0d cycles", timeLimit);
            end
        end
        if (!timedOut) begin
            finalChecks();
        end
        $display("Errors: %0d, fetches: %0d, loads: %0d, stores: %0d, cycles: %0d",
                 errors, fetches, loads, stores, cycles);
        if (!timedOut && errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- hdl/mipsCpuBus.sv
module mipsCpuBus #(
    parameter mipsPkg::word_t resetVector = mipsPkg::defaultResetVector
) (
    input  logic           clk,
    input  logic           reset,
    output logic           active,
    output mipsPkg::word_t registerV0,
    // Avalon master
    output mipsPkg::word_t address,
    output logic           read,
    output logic           write,
    input  logic           waitrequest,
    output mipsPkg::word_t writedata,
    output logic [3:0]     byteenable,
    input  mipsPkg::word_t readdata
);
    import mipsPkg::*;

    // Sequencing
    word_t instr;
    word_t pc;
    logic exStep;
    logic wbStep;

    // Decoded fields
    aluOp_t aluOp;
    regIdx_t rs;
    regIdx_t rt;
    regIdx_t destReg;
    logic [4:0] shamt;
    word_t immExt;
    logic useImm;
    logic isLoad;
    logic isStore;
    logic isBranchEq;
    logic isBranchNe;
    logic isJump;
    logic isJumpReg;
    logic isRedirect;
    logic regWrite;

    // Operands and results
    word_t rsValue;
    word_t rtValue;
    word_t aluResult;
    logic redirectValid;
    word_t redirectTarget;

    // Store data is always rt
    cpuControl #(.resetVector(resetVector)) uControl (
        .storeValue(rtValue),
        .*
    );

    instrDecode uDecode (.*);

    // J index is the low 26 bits of the instruction
    aluExecute uExecute (
        .jumpIndex(instr[25:0]),
        .*
    );

    regWriteBack uRegs (.*);

endmodule

//--- hdl/regWriteBack.sv
module regWriteBack (
    input  logic             clk,
    input  logic             reset,
    input  mipsPkg::regIdx_t rs,
    input  mipsPkg::regIdx_t rt,
    input  mipsPkg::regIdx_t destReg,
    input  logic             wbStep,
    input  logic             regWrite,
    input  logic             isLoad,
    input  mipsPkg::word_t   aluResult,
    input  mipsPkg::word_t   readdata,
    output mipsPkg::word_t   rsValue,
    output mipsPkg::word_t   rtValue,
    output mipsPkg::word_t   registerV0
);
    import mipsPkg::*;

    word_t regs [32];
    // Bus word of the previous cycle, the completing MEM cycle when in WB
    word_t loadWord;
    word_t wbValue;

    // Register zero reads as zero
    assign rsValue = (rs == '0) ? '0 : regs[rs];
    assign rtValue = (rt == '0) ? '0 : regs[rt];
    assign registerV0 = regs[regV0];

    // Loads come back in bus byte order
    assign wbValue = isLoad ? byteSwap(loadWord) : aluResult;

    always_ff @(posedge clk) begin
        loadWord <= readdata;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbStep && regWrite && (destReg != '0)) begin
            regs[destReg] <= wbValue;
        end
    end

endmodule

//--- hdl/aluExecute.sv
module aluExecute (
    input  logic            clk,
    input  logic            exStep,
    input  mipsPkg::aluOp_t aluOp,
    input  mipsPkg::word_t  rsValue,
    input  mipsPkg::word_t  rtValue,
    input  mipsPkg::word_t  immExt,
    input  mipsPkg::word_t  pc,
    input  logic            useImm,
    input  logic [4:0]      shamt,
    input  logic            isBranchEq,
    input  logic            isBranchNe,
    input  logic            isJump,
    input  logic            isJumpReg,
    input  logic [25:0]     jumpIndex,
    output mipsPkg::word_t  aluResult,
    output logic            redirectValid,
    output mipsPkg::word_t  redirectTarget
);
    import mipsPkg::*;

    word_t operandB;
    logic [4:0] shiftAmt;
    word_t result;
    word_t pcPlus4;
    word_t target;
    logic taken;

    // Immediate or rt as second operand
    assign operandB = useImm ? immExt : rtValue;
    // Variable shifts use the low bits of rs
    assign shiftAmt = useImm ? shamt : rsValue[4:0];

    always_comb begin
        case (aluOp)
            aluAdd:  result = rsValue + operandB;
            aluSub:  result = rsValue - operandB;
            aluAnd:  result = rsValue & operandB;
            aluOr:   result = rsValue | operandB;
            aluXor:  result = rsValue ^ operandB;
            aluSlt:  result = {31'd0, $signed(rsValue) < $signed(operandB)};
            aluSltu: result = {31'd0, rsValue < operandB};
            // Shifts operate on rt
            aluSll:  result = rtValue << shiftAmt;
            aluSrl:  result = rtValue >> shiftAmt;
            aluSra:  result = $signed(rtValue) >>> shiftAmt;
            aluLui:  result = {immExt[15:0], 16'h0000};
            default: result = rsValue + operandB;
        endcase
    end

    // Branch and jump targets are relative to the delay slot address
    assign pcPlus4 = pc + 32'd4;
    assign taken = (isBranchEq && (rsValue == rtValue))
                || (isBranchNe && (rsValue != rtValue))
                || isJump
                || isJumpReg;

    always_comb begin
        if (isJumpReg) begin
            target = rsValue;
        end else if (isJump) begin
            target = {pcPlus4[31:28], jumpIndex, 2'b00};
        end else begin
            target = pcPlus4 + {immExt[29:0], 2'b00};
        end
    end

    // Captured at the end of EX, held until the next EX
    always_ff @(posedge clk) begin
        if (exStep) begin
            aluResult <= result;
            redirectValid <= taken;
            redirectTarget <= target;
        end
    end

endmodule

//--- hdl/instrDecode.sv
module instrDecode (
    input  mipsPkg::word_t   instr,
    output mipsPkg::aluOp_t  aluOp,
    output mipsPkg::regIdx_t rs,
    output mipsPkg::regIdx_t rt,
    output mipsPkg::regIdx_t destReg,
    output logic [4:0]       shamt,
    output mipsPkg::word_t   immExt,
    output logic             useImm,
    output logic             isLoad,
    output logic             isStore,
    output logic             isBranchEq,
    output logic             isBranchNe,
    output logic             isJump,
    output logic             isJumpReg,
    output logic             isRedirect,
    output logic             regWrite
);
    import mipsPkg::*;

    opcode_t opcode;
    funct_t funct;
    logic [15:0] imm;
    logic rType;
    logic logicImm;

    // Field split
    assign opcode = opcode_t'(instr[31:26]);
    assign funct = funct_t'(instr[5:0]);
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign shamt = instr[10:6];
    assign imm = instr[15:0];

    assign rType = (opcode == opSpecial);
    // rd for R-type, rt for immediates and loads
    assign destReg = rType ? instr[15:11] : instr[20:16];

    assign isLoad = (opcode == opLw);
    assign isStore = (opcode == opSw);
    assign isBranchEq = (opcode == opBeq);
    assign isBranchNe = (opcode == opBne);
    assign isJump = (opcode == opJ);
    assign isJumpReg = rType && (funct == fnJr);
    // Taken or not, all of these have a delay slot
    assign isRedirect = isBranchEq || isBranchNe || isJump || isJumpReg;

    // Logical immediates are zero extended, the rest sign extended
    assign logicImm = (opcode == opAndi) || (opcode == opOri) || (opcode == opXori);
    assign immExt = logicImm ? {16'h0000, imm} : {{16{imm[15]}}, imm};

    always_comb begin
        // Address add by default, covers LW and SW
        aluOp = aluAdd;
        useImm = 1'b1;
        regWrite = 1'b0;
        case (opcode)
            opSpecial: begin
                useImm = 1'b0;
                regWrite = 1'b1;
                case (funct)
                    fnAddu: aluOp = aluAdd;
                    fnSubu: aluOp = aluSub;
                    fnAnd:  aluOp = aluAnd;
                    fnOr:   aluOp = aluOr;
                    fnXor:  aluOp = aluXor;
                    fnSlt:  aluOp = aluSlt;
                    fnSltu: aluOp = aluSltu;
                    // Fixed shifts take shamt
                    fnSll: begin
                        aluOp = aluSll;
                        useImm = 1'b1;
                    end
                    fnSrl: begin
                        aluOp = aluSrl;
                        useImm = 1'b1;
                    end
                    fnSra: begin
                        aluOp = aluSra;
                        useImm = 1'b1;
                    end
                    fnSllv: aluOp = aluSll;
                    fnSrlv: aluOp = aluSrl;
                    fnSrav: aluOp = aluSra;
                    // JR and unknown codes write nothing
                    default: regWrite = 1'b0;
                endcase
            end
            opAddiu: regWrite = 1'b1;
            opSlti: begin
                aluOp = aluSlt;
                regWrite = 1'b1;
            end
            opSltiu: begin
                aluOp = aluSltu;
                regWrite = 1'b1;
            end
            opAndi: begin
                aluOp = aluAnd;
                regWrite = 1'b1;
            end
            opOri: begin
                aluOp = aluOr;
                regWrite = 1'b1;
            end
            opXori: begin
                aluOp = aluXor;
                regWrite = 1'b1;
            end
            opLui: begin
                aluOp = aluLui;
                regWrite = 1'b1;
            end
            opLw: regWrite = 1'b1;
            default: regWrite = 1'b0;
        endcase
    end

endmodule

//--- hdl/cpuControl.sv
module cpuControl #(
    parameter mipsPkg::word_t resetVector = mipsPkg::defaultResetVector
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           waitrequest,
    input  mipsPkg::word_t readdata,
    input  logic           isLoad,
    input  logic           isStore,
    input  logic           isRedirect,
    input  logic           redirectValid,
    input  mipsPkg::word_t redirectTarget,
    input  mipsPkg::word_t aluResult,
    input  mipsPkg::word_t storeValue,
    output mipsPkg::word_t instr,
    output mipsPkg::word_t pc,
    output logic           exStep,
    output logic           wbStep,
    output mipsPkg::word_t address,
    output logic           read,
    output logic           write,
    output mipsPkg::word_t writedata,
    output logic [3:0]     byteenable,
    output logic           active
);
    import mipsPkg::*;

    cpuState_t state;
    // Address the PC moves to when this instruction retires
    word_t nextPc;
    // Set after a branch or jump, consumed by the delay slot fetch
    logic pendingArm;

    assign exStep = (state == EX);
    assign wbStep = (state == WB);
    assign active = (state != HALT);

    // Bus master, fetch in IF and data access in MEM
    assign address = (state == MEM) ? aluResult : pc;
    assign read = (state == IF) || ((state == MEM) && isLoad);
    assign write = (state == MEM) && isStore;
    assign writedata = byteSwap(storeValue);
    // Word accesses only
    assign byteenable = 4'b1111;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IF;
            pc <= resetVector;
            nextPc <= resetVector + 32'd4;
            pendingArm <= 1'b0;
        end else begin
            case (state)
                IF: begin
                    // Hold until the fetch completes
                    if (!waitrequest) begin
                        state <= ID;
                        pendingArm <= 1'b0;
                        // Delay slot fetch, taken target replaces the increment
                        if (pendingArm && redirectValid) begin
                            nextPc <= redirectTarget;
                        end else begin
                            nextPc <= pc + 32'd4;
                        end
                    end
                end
                ID: begin
                    // Fetch from address zero ends the run
                    if (pc == '0) begin
                        state <= HALT;
                    end else begin
                        state <= EX;
                    end
                end
                EX: begin
                    if (isRedirect) begin
                        // Branches and jumps retire here
                        state <= IF;
                        pc <= nextPc;
                        pendingArm <= 1'b1;
                    end else if (isLoad || isStore) begin
                        state <= MEM;
                    end else begin
                        state <= WB;
                    end
                end
                MEM: begin
                    if (!waitrequest) begin
                        if (isLoad) begin
                            state <= WB;
                        end else begin
                            // Stores skip WB
                            state <= IF;
                            pc <= nextPc;
                        end
                    end
                end
                WB: begin
                    state <= IF;
                    pc <= nextPc;
                end
                default: begin
                    state <= HALT;
                end
            endcase
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if ((state == IF) && !waitrequest) begin
            instr <= byteSwap(readdata);
        end
    end

endmodule

//--- hdl/mipsPkg.sv
package mipsPkg;

    // Data path widths
    typedef logic [31:0] word_t;
    typedef logic [4:0] regIdx_t;

    // First fetch address after reset
    localparam word_t defaultResetVector = 32'hBFC00000;
    // Register holding the return value
    localparam regIdx_t regV0 = 5'd2;

    // Multicycle control states
    typedef enum logic [2:0] {IF, ID, EX, MEM, WB, HALT} cpuState_t;

    // Primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        opSpecial = 6'd0,
        opJ       = 6'd2,
        opBeq     = 6'd4,
        opBne     = 6'd5,
        opAddiu   = 6'd9,
        opSlti    = 6'd10,
        opSltiu   = 6'd11,
        opAndi    = 6'd12,
        opOri     = 6'd13,
        opXori    = 6'd14,
        opLui     = 6'd15,
        opLw      = 6'd35,
        opSw      = 6'd43
    } opcode_t;

    // R-type function codes, instr[5:0]
    typedef enum logic [5:0] {
        fnSll  = 6'd0,
        fnSrl  = 6'd2,
        fnSra  = 6'd3,
        fnSllv = 6'd4,
        fnSrlv = 6'd6,
        fnSrav = 6'd7,
        fnJr   = 6'd8,
        fnAddu = 6'd33,
        fnSubu = 6'd35,
        fnAnd  = 6'd36,
        fnOr   = 6'd37,
        fnXor  = 6'd38,
        fnSlt  = 6'd42,
        fnSltu = 6'd43
    } funct_t;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
    } aluOp_t;

    // Bus carries the word with its bytes in reverse order
    function automatic word_t byteSwap(input word_t value);
        return {value[7:0], value[15:8], value[23:16], value[31:24]};
    endfunction

endpackage
